// ==== sim.f ====
+incdir+include
rtl/rv32_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/issue_stage.sv
rtl/pipe_reg.sv
rtl/exec_core.sv
sim/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rv32_pkg.sv
      - rtl/alu.sv
      - rtl/reg_file.sv
      - rtl/issue_stage.sv
      - rtl/pipe_reg.sv
      - rtl/exec_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/exec_core_tb.sv

// ==== sim/exec_core_tb.sv ====
`timescale 1ns/1ns
`include "rv32_settings.svh"

module exec_core_tb
        import rv32_pkg::*;
        ();

localparam int rand_slots_lp  = 1700;
localparam int max_instr_lp   = 2000;  // reset, both scans, the random stream and the drain.
localparam int cycle_limit_lp = max_instr_lp + 50;

localparam logic [2:0] id_reset_x0  = 3'd0;
localparam logic [2:0] id_alu       = 3'd1;
localparam logic [2:0] id_imm_addr  = 3'd2;
localparam logic [2:0] id_branch    = 3'd3;
localparam logic [2:0] id_reg_state = 3'd4;
localparam logic [2:0] id_auto      = 3'd7;

typedef struct packed {
        logic        v;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] result;
        logic        chk_result;
        logic        br;
        logic        taken;
        logic [2:0]  test_id;
} expect_s;

logic         clk;
logic         reset;
logic         instr_v;
instruction_s instr;
logic         result_v;
logic [4:0]   rd;
logic         rd_we;
logic [31:0]  result;
logic         branch_v;
logic         branch_taken;

logic [31:0]  model_regs [0:31];
logic [31:0]  lcg_state;
expect_s      exp_q [$];
int           error_count;
int           cycle_count;

exec_core dut (
        .clk_i(clk), .reset_i(reset), .instr_v_i(instr_v), .instr_i(instr),
        .result_v_o(result_v), .rd_o(rd), .rd_we_o(rd_we), .result_o(result),
        .branch_v_o(branch_v), .branch_taken_o(branch_taken));

initial
begin
        clk = 1'b0;
        forever #10 clk = ~clk;
end

// ***********************************************************
// random instruction stream.
// ***********************************************************
function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);  // folds the better high bits down.
endfunction

// most picks come from x0..x7 so that dependent pairs are frequent.
function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        if (r[7:6] == 2'b00)
                return r[12:8];
        return {2'b00, r[10:8]};
endfunction

function automatic logic [31:0] lr_w(input logic [4:0] rd_f, input logic [4:0] rs1_f);
        return {5'b00010, 2'b00, 5'b00000, rs1_f, 3'b010, rd_f, 7'b0101111};
endfunction

function automatic logic [31:0] random_word();
        logic [31:0] r;
        logic [31:0] imm;
        logic [4:0]  rd_f;
        logic [4:0]  rs1_f;
        logic [4:0]  rs2_f;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r     = next_rand();
        imm   = next_rand();
        rd_f  = pick_reg();
        rs1_f = pick_reg();
        rs2_f = (r[5:4] == 2'b00) ? rs1_f : pick_reg();  // equal operands now and then.
        f3    = r[10:8];
        f7    = ((f3 == 3'd0 || f3 == 3'd5) && r[11]) ? 7'b0100000 : 7'b0000000;
        if (r[13:12] == 2'b00)
                imm[31:12] = {r[14], {19{r[15]}}};  // sign-boundary immediates.
        case (r[3:0])
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
                return {f7, rs2_f, rs1_f, f3, rd_f, `RV32_OP};
        4'd5, 4'd6, 4'd7, 4'd8:
                if (f3 == 3'd1 || f3 == 3'd5)
                        return {f7, imm[24:20], rs1_f, f3, rd_f, `RV32_OP_IMM};
                else
                        return {imm[31:20], rs1_f, f3, rd_f, `RV32_OP_IMM};
        4'd9:
                return {imm[31:12], rd_f, `RV32_LUI_OP};
        4'd10:
                return {imm[31:12], rd_f, `RV32_AUIPC_OP};
        4'd11:
                return {imm[31:20], rs1_f, (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3, rd_f,
                        `RV32_LOAD};
        4'd12:
                return {imm[31:25], rs2_f, rs1_f, (f3 > 3'd2) ? 3'd2 : f3, imm[11:7],
                        `RV32_STORE};
        4'd13, 4'd14:
                return {imm[31:25], rs2_f, rs1_f, (f3[2:1] == 2'b01) ? f3 + 3'd2 : f3,
                        imm[11:7], `RV32_BRANCH};
        default:
                if (r[11])
                        return {imm[31:20], rs1_f, 3'b000, rd_f, `RV32_JALR_OP};
                else
                        return lr_w(rd_f, rs1_f);
        endcase
endfunction

// ***********************************************************
// reference model, run in program order at issue.
// ***********************************************************
function automatic expect_s model_exec(input logic [31:0] w);
        expect_s     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] i_imm;
        a            = model_regs[w[19:15]];
        i_imm        = {{20{w[31]}}, w[31:20]};
        b            = (w[6:0] == `RV32_OP || w[6:0] == `RV32_BRANCH) ? model_regs[w[24:20]]
                                                                      : i_imm;
        e            = '0;
        e.v          = 1'b1;
        e.we         = 1'b1;
        e.rd         = w[11:7];
        e.chk_result = 1'b1;
        e.test_id    = id_imm_addr;
        case (w[6:0])
        `RV32_OP, `RV32_OP_IMM:
        begin
                e.test_id = id_alu;
                case (w[14:12])
                3'd0: e.result = (w[6:0] == `RV32_OP && w[30]) ? a - b : a + b;
                3'd1: e.result = a << b[4:0];
                3'd2: e.result = {31'd0, $signed(a) < $signed(b)};
                3'd3: e.result = {31'd0, a < b};
                3'd4: e.result = a ^ b;
                3'd5:
                        if (w[30])
                                e.result = $signed(a) >>> b[4:0];
                        else
                                e.result = a >> b[4:0];
                3'd6: e.result = a | b;
                default: e.result = a & b;
                endcase
        end
        `RV32_BRANCH:
        begin
                e.test_id    = id_branch;
                e.we         = 1'b0;
                e.br         = 1'b1;
                e.chk_result = 1'b0;
                case (w[14:12])
                3'b000: e.taken = (a == b);
                3'b001: e.taken = (a != b);
                3'b100: e.taken = ($signed(a) < $signed(b));
                3'b101: e.taken = ($signed(a) >= $signed(b));
                3'b110: e.taken = (a < b);
                default: e.taken = (a >= b);
                endcase
        end
        `RV32_LOAD:
        begin
                e.result = a + i_imm;
                e.we     = 1'b0;  // there is no data memory behind the address.
        end
        `RV32_STORE:
        begin
                e.result = a + {{20{w[31]}}, w[31:25], w[11:7]};
                e.we     = 1'b0;
        end
        `RV32_LUI_OP, `RV32_AUIPC_OP:
                e.result = {w[31:12], 12'h000};
        `RV32_JALR_OP:
                e.result = (a + i_imm) & ~32'd1;
        default:
                e.result = a;  // lr.w returns its address register.
        endcase
        if (e.rd == 5'd0)
                e.we = 1'b0;
        if (e.we)
                model_regs[e.rd] = e.result;
        return e;
endfunction

function automatic string test_name(input logic [2:0] id);
        case (id)
        id_reset_x0:  return "reset_and_x0";
        id_alu:       return "arith_logic";
        id_imm_addr:  return "imm_and_addr";
        id_branch:    return "branch";
        id_reg_state: return "reg_state";
        default:      return "bubble";
        endcase
endfunction

// ***********************************************************
// checking.
// ***********************************************************
task automatic stop_with_failure(input string reason);
        error_count++;
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped.");
endtask

task automatic report_mismatch(input string test, input string sig,
                               input logic [31:0] exp, input logic [31:0] act);
        stop_with_failure($sformatf("MISMATCH test=%s signal=%s expected=0x%h actual=0x%h",
                                    test, sig, exp, act));
endtask

task automatic check_outputs(input expect_s e);
        string name;
        name = test_name(e.test_id);
        assert (result_v === e.v)
        else report_mismatch(name, "result_v_o", 32'(e.v), 32'(result_v));
        assert (rd_we === e.we)
        else report_mismatch(name, "rd_we_o", 32'(e.we), 32'(rd_we));
        assert (branch_v === e.br)
        else report_mismatch(name, "branch_v_o", 32'(e.br), 32'(branch_v));
        assert (branch_taken === e.taken)
        else report_mismatch(name, "branch_taken_o", 32'(e.taken), 32'(branch_taken));
        if (e.we)
                assert (rd === e.rd)
                else report_mismatch(name, "rd_o", 32'(e.rd), 32'(rd));
        if (e.v && e.chk_result)
                assert (result === e.result)
                else report_mismatch(name, "result_o", e.result, result);
endtask

// one cycle: check the slot issued two cycles ago, then drive the next one.
task automatic issue_slot(input logic valid, input logic [31:0] word, input logic [2:0] id);
        expect_s e;
        @(posedge clk);
        #1;
        check_outputs(exp_q.pop_front());
        #1;
        if (valid)
                e = model_exec(word);
        else
                e = '0;
        if (!valid || id != id_auto)
                e.test_id = id;
        instr_v = valid;
        instr   = word;
        exp_q.push_back(e);
endtask

// lr.w with rd of x0 reads a register without writing one.
task automatic scan_registers(input logic [2:0] id);
        for (int i = 0; i < 32; i++)
                issue_slot(1'b1, lr_w(5'd0, i[4:0]), id);
endtask

initial
begin
        logic [31:0] r;
        lcg_state   = 32'hca4d_f4ed;
        error_count = 0;
        reset       = 1'b1;
        instr_v     = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++)
                model_regs[i] = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        exp_q.push_back('0);  // nothing is in flight right after reset.
        exp_q.push_back('0);
        scan_registers(id_reset_x0);
        for (int n = 0; n < rand_slots_lp; n++)
        begin
                r = next_rand();
                if (r[2:0] == 3'd0)
                        issue_slot(1'b0, next_rand(), id_auto);
                else
                        issue_slot(1'b1, random_word(), id_auto);
        end
        scan_registers(id_reg_state);
        issue_slot(1'b0, '0, id_reg_state);
        issue_slot(1'b0, '0, id_reg_state);
        if (error_count == 0)
        begin
                $display("*** TEST PASSED ***");
                $finish;
        end
        else
                stop_with_failure("the run ended with failed checks.");
end

initial
begin
        cycle_count = 0;
        forever
        begin
                @(posedge clk);
                cycle_count++;
                if (cycle_count > cycle_limit_lp)
                        stop_with_failure("timeout: the run went past its cycle limit.");
        end
end

endmodule

// ==== rtl/exec_core.sv ====
`timescale 1ns/1ns
`include "rv32_settings.svh"

module exec_core
        import rv32_pkg::*;
        (
        input  logic                               clk_i,
        input  logic                               reset_i,
        input  logic                               instr_v_i,
        input  instruction_s                       instr_i,
        output logic                               result_v_o,
        output logic [`RV32_reg_addr_width_gp-1:0] rd_o,
        output logic                               rd_we_o,
        output logic [`RV32_reg_data_width_gp-1:0] result_o,
        output logic                               branch_v_o,
        output logic                               branch_taken_o
        );

logic [`RV32_reg_addr_width_gp-1:0] rs1_addr, rs2_addr;
logic [`RV32_reg_data_width_gp-1:0] rs1_data, rs2_data;
logic [`RV32_reg_data_width_gp-1:0] alu_result;
logic                               alu_jump;
id_ex_s                             id_ex_d, id_ex_q;
ex_wb_s                             ex_wb_d, ex_wb_q;
logic                               id_ex_v, ex_wb_v;

// ***********************************************************
// issue.
// ***********************************************************
issue_stage issue (
        .clk_i(clk_i), .instr_v_i(instr_v_i), .instr_i(instr_i),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_v_i(id_ex_v), .ex_rd_i(id_ex_q.rd),
        .ex_we_i(id_ex_q.writes_rd), .ex_result_i(alu_result),
        .wb_v_i(ex_wb_v), .wb_rd_i(ex_wb_q.rd),
        .wb_we_i(ex_wb_q.writes_rd), .wb_result_i(ex_wb_q.result),
        .payload_o(id_ex_d));

pipe_reg #(.payload_t(id_ex_s)) id_ex (
        .clk_i(clk_i), .reset_i(reset_i),
        .v_i(instr_v_i), .data_i(id_ex_d),
        .v_o(id_ex_v), .data_o(id_ex_q));

// ***********************************************************
// execute.
// ***********************************************************
alu ex_alu (
        .rs1_i(id_ex_q.rs1_val), .rs2_i(id_ex_q.rs2_val), .op_i(id_ex_q.instr),
        .result_o(alu_result), .jump_now_o(alu_jump));

assign ex_wb_d.rd        = id_ex_q.rd;
assign ex_wb_d.writes_rd = id_ex_q.writes_rd;
assign ex_wb_d.result    = alu_result;
assign ex_wb_d.is_branch = (id_ex_q.instr.op ==? `RV32_BRANCH);
assign ex_wb_d.jump      = alu_jump;

pipe_reg #(.payload_t(ex_wb_s)) ex_wb (
        .clk_i(clk_i), .reset_i(reset_i),
        .v_i(id_ex_v), .data_i(ex_wb_d),
        .v_o(ex_wb_v), .data_o(ex_wb_q));

// ***********************************************************
// writeback.
// ***********************************************************
reg_file rf (
        .clk_i(clk_i), .reset_i(reset_i),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rd_we_o), .wa_i(ex_wb_q.rd), .wd_i(ex_wb_q.result));

assign result_v_o     = ex_wb_v;
assign rd_o           = ex_wb_q.rd;
assign rd_we_o        = ex_wb_v & ex_wb_q.writes_rd;
assign result_o       = ex_wb_q.result;
assign branch_v_o     = ex_wb_v & ex_wb_q.is_branch;
assign branch_taken_o = branch_v_o & ex_wb_q.jump;  // low whenever no branch retires.

endmodule

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg
        #(parameter type payload_t = logic)
        (
        input  logic     clk_i,
        input  logic     reset_i,
        input  logic     v_i,
        input  payload_t data_i,
        output logic     v_o,
        output payload_t data_o
        );

always_ff @(posedge clk_i)
begin
        if (reset_i)
                v_o <= 1'b0;
        else
                v_o <= v_i;
end

// payload follows the valid bit and may hold stale data when v_o is low.
always_ff @(posedge clk_i)
begin
        data_o <= data_i;
end

endmodule

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ns
`include "rv32_settings.svh"

module issue_stage
        import rv32_pkg::*;
        (
        input  logic                               clk_i,
        input  logic                               instr_v_i,
        input  instruction_s                       instr_i,
        output logic [`RV32_reg_addr_width_gp-1:0] rs1_addr_o,
        output logic [`RV32_reg_addr_width_gp-1:0] rs2_addr_o,
        input  logic [`RV32_reg_data_width_gp-1:0] rs1_data_i,
        input  logic [`RV32_reg_data_width_gp-1:0] rs2_data_i,
        input  logic                               ex_v_i,
        input  logic [`RV32_reg_addr_width_gp-1:0] ex_rd_i,
        input  logic                               ex_we_i,
        input  logic [`RV32_reg_data_width_gp-1:0] ex_result_i,
        input  logic                               wb_v_i,
        input  logic [`RV32_reg_addr_width_gp-1:0] wb_rd_i,
        input  logic                               wb_we_i,
        input  logic [`RV32_reg_data_width_gp-1:0] wb_result_i,
        output id_ex_s                             payload_o
        );

logic writes_rd;
logic supported;

// the younger result in EX has priority over the one in WB.
function automatic logic [`RV32_reg_data_width_gp-1:0] forward
        (input logic [`RV32_reg_addr_width_gp-1:0] addr,
         input logic [`RV32_reg_data_width_gp-1:0] rf_data);
        logic [`RV32_reg_data_width_gp-1:0] value;
        value = rf_data;
        if (addr != '0)
        begin
                if (ex_v_i && ex_we_i && (ex_rd_i == addr))
                        value = ex_result_i;
                else if (wb_v_i && wb_we_i && (wb_rd_i == addr))
                        value = wb_result_i;
        end
        return value;
endfunction

assign rs1_addr_o = instr_i.rs1;
assign rs2_addr_o = instr_i.rs2;

// loads write nothing here, as there is no data memory.
assign writes_rd = (instr_i.rd != '0)
                 & ((instr_i.op ==? `RV32_LUI_OP) | (instr_i.op ==? `RV32_AUIPC_OP)
                  | (instr_i.op ==? `RV32_OP) | (instr_i.op ==? `RV32_OP_IMM)
                  | (instr_i.op ==? `RV32_JALR_OP) | (instr_i ==? `RV32_LR_W));

always_comb
begin
        payload_o.instr     = instr_i;
        payload_o.rs1_val   = forward(instr_i.rs1, rs1_data_i);
        payload_o.rs2_val   = forward(instr_i.rs2, rs2_data_i);
        payload_o.writes_rd = writes_rd;
        payload_o.rd        = instr_i.rd;
end

// ***********************************************************
// input checks.
// ***********************************************************
assign supported = (instr_i.op ==? `RV32_LUI_OP) | (instr_i.op ==? `RV32_AUIPC_OP)
                 | (instr_i.op ==? `RV32_OP) | (instr_i.op ==? `RV32_OP_IMM)
                 | (instr_i.op ==? `RV32_LOAD) | (instr_i.op ==? `RV32_STORE)
                 | (instr_i.op ==? `RV32_BRANCH) | (instr_i.op ==? `RV32_JALR_OP)
                 | (instr_i ==? `RV32_LR_W);

a_supported: assert property (@(posedge clk_i) instr_v_i |-> supported)
        else $error("issue_stage: unsupported instruction %h.", instr_i);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns
`include "rv32_settings.svh"

module reg_file
        (
        input  logic                               clk_i,
        input  logic                               reset_i,
        input  logic [`RV32_reg_addr_width_gp-1:0] rs1_addr_i,
        input  logic [`RV32_reg_addr_width_gp-1:0] rs2_addr_i,
        output logic [`RV32_reg_data_width_gp-1:0] rs1_data_o,
        output logic [`RV32_reg_data_width_gp-1:0] rs2_data_o,
        input  logic                               we_i,
        input  logic [`RV32_reg_addr_width_gp-1:0] wa_i,
        input  logic [`RV32_reg_data_width_gp-1:0] wd_i
        );

// x0 has no storage.
logic [`RV32_reg_data_width_gp-1:0] regs_r [1:`RV32_reg_els_gp-1];

always_ff @(posedge clk_i)
begin
        if (reset_i)
        begin
                for (int i = 1; i < `RV32_reg_els_gp; i++)
                        regs_r[i] <= '0;
        end
        else if (we_i && (wa_i != '0))
                regs_r[wa_i] <= wd_i;
end

assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_r[rs1_addr_i];
assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_r[rs2_addr_i];

// the issue stage clears writes_rd for rd of zero, so no write reaches x0.
a_no_x0_write: assert property (@(posedge clk_i) disable iff (reset_i)
        we_i |-> (wa_i != '0))
        else $error("reg_file: write enable raised for x0.");

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ns
`include "rv32_settings.svh"

module alu
        import rv32_pkg::*;
        (
        input  logic [`RV32_reg_data_width_gp-1:0] rs1_i,
        input  logic [`RV32_reg_data_width_gp-1:0] rs2_i,
        input  instruction_s                       op_i,
        output logic [`RV32_reg_data_width_gp-1:0] result_o,
        output logic                               jump_now_o
        );

localparam int width_lp = `RV32_reg_data_width_gp;

logic                is_imm_op;
logic                is_store;
logic                sub_not_add;
logic                shift_fill;
logic                carry;
logic                sum_is_zero;
logic [4:0]          sh_amount;
logic [width_lp-1:0] op2;
logic [width_lp-1:0] adder_b;
logic [width_lp:0]   sum;
logic [width_lp:0]   shr_out;
logic [width_lp-1:0] shl_out;

// ***********************************************************
// operand select and the shared adder.
// ***********************************************************
assign is_imm_op = (op_i.op ==? `RV32_OP_IMM) | (op_i.op ==? `RV32_LOAD)
                 | (op_i.op ==? `RV32_JALR_OP);
assign is_store  = (op_i.op ==? `RV32_STORE);

always_comb
begin
        if (is_store)
                op2 = `RV32_signext_Simm(op_i);
        else if (is_imm_op)
                op2 = `RV32_signext_Iimm(op_i);
        else
                op2 = rs2_i;
end

// compares of every kind subtract.
assign sub_not_add = (op_i.op ==? `RV32_BRANCH) | (op_i ==? `RV32_SUB)
                   | (op_i ==? `RV32_SLT) | (op_i ==? `RV32_SLTI)
                   | (op_i ==? `RV32_SLTU) | (op_i ==? `RV32_SLTIU);

assign adder_b = sub_not_add ? ~op2 : op2;

// sign-extended to 33 bits so sum[32] is the signed less-than.
assign {carry, sum} = {rs1_i[width_lp-1], rs1_i} + {adder_b[width_lp-1], adder_b}
                    + sub_not_add;
assign sum_is_zero = (sum[width_lp-1:0] == '0);

// ***********************************************************
// shifter.
// ***********************************************************
assign sh_amount  = is_imm_op ? op_i.rs2 : rs2_i[4:0];
assign shift_fill = ((op_i ==? `RV32_SRA) | (op_i ==? `RV32_SRAI)) & rs1_i[width_lp-1];
assign shr_out    = $signed({shift_fill, rs1_i}) >>> sh_amount;
assign shl_out    = rs1_i << sh_amount;

// ***********************************************************
// result and branch decision.
// ***********************************************************
always_comb
begin
        result_o   = '0;
        jump_now_o = 1'b0;  // only branches drive it high.

        unique casez (op_i)
        `RV32_LUI, `RV32_AUIPC:
                result_o = `RV32_signext_Uimm(op_i);
        `RV32_ADDI, `RV32_ADD, `RV32_SUB,
        `RV32_LB, `RV32_LH, `RV32_LW, `RV32_LBU, `RV32_LHU,
        `RV32_SB, `RV32_SH, `RV32_SW:
                result_o = sum[width_lp-1:0];
        `RV32_LR_W:
                result_o = rs1_i;  // the address is the register itself.
        `RV32_SLTI, `RV32_SLT:
                result_o = {{(width_lp-1){1'b0}}, sum[width_lp]};
        `RV32_SLTIU, `RV32_SLTU:
                result_o = {{(width_lp-1){1'b0}}, ~carry};
        `RV32_XORI, `RV32_XOR:
                result_o = rs1_i ^ op2;
        `RV32_ORI, `RV32_OR:
                result_o = rs1_i | op2;
        `RV32_ANDI, `RV32_AND:
                result_o = rs1_i & op2;
        `RV32_SLLI, `RV32_SLL:
                result_o = shl_out;
        `RV32_SRLI, `RV32_SRL, `RV32_SRAI, `RV32_SRA:
                result_o = shr_out[width_lp-1:0];
        `RV32_JALR:
                result_o = {sum[width_lp-1:1], 1'b0};
        `RV32_BEQ:
                jump_now_o = sum_is_zero;
        `RV32_BNE:
                jump_now_o = ~sum_is_zero;
        `RV32_BLT:
                jump_now_o = sum[width_lp];
        `RV32_BGE:
                jump_now_o = ~sum[width_lp];
        `RV32_BLTU:
                jump_now_o = ~carry;  // a borrow out means rs1 is below rs2.
        `RV32_BGEU:
                jump_now_o = carry;
        default:
        begin
                result_o   = '0;
                jump_now_o = 1'b0;
        end
        endcase
end

endmodule

// ==== rtl/rv32_pkg.sv ====
`include "rv32_settings.svh"

package rv32_pkg;

        // ***********************************************************
        // instruction word, laid out as the R-type fields.
        // ***********************************************************
        typedef struct packed {
                logic [6:0]                           funct7;
                logic [`RV32_reg_addr_width_gp-1:0]   rs2;
                logic [`RV32_reg_addr_width_gp-1:0]   rs1;
                logic [2:0]                           funct3;
                logic [`RV32_reg_addr_width_gp-1:0]   rd;
                logic [6:0]                           op;
        } instruction_s;

        // issue to execute.
        typedef struct packed {
                instruction_s                         instr;
                logic [`RV32_reg_data_width_gp-1:0]   rs1_val;  // already bypassed.
                logic [`RV32_reg_data_width_gp-1:0]   rs2_val;
                logic                                 writes_rd;
                logic [`RV32_reg_addr_width_gp-1:0]   rd;
        } id_ex_s;

        // execute to writeback.
        typedef struct packed {
                logic [`RV32_reg_addr_width_gp-1:0]   rd;
                logic                                 writes_rd;
                logic [`RV32_reg_data_width_gp-1:0]   result;
                logic                                 is_branch;
                logic                                 jump;  // branch taken.
        } ex_wb_s;

endpackage

// ==== include/rv32_settings.svh ====
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// ***********************************************************
// datapath and register file sizes.
// ***********************************************************
`define RV32_reg_data_width_gp 32
`define RV32_reg_addr_width_gp 5
`define RV32_reg_els_gp        32

// major opcodes, matched against the 7-bit op field.
`define RV32_OP       7'b0110011
`define RV32_OP_IMM   7'b0010011
`define RV32_LOAD     7'b0000011
`define RV32_STORE    7'b0100011
`define RV32_BRANCH   7'b1100011
`define RV32_JALR_OP  7'b1100111
`define RV32_LUI_OP   7'b0110111
`define RV32_AUIPC_OP 7'b0010111

// ***********************************************************
// whole-instruction casez patterns.
// ***********************************************************
`define RV32_LUI   32'b????????????????????_?????_0110111
`define RV32_AUIPC 32'b????????????????????_?????_0010111
`define RV32_JALR  32'b????????????_?????_000_?????_1100111
`define RV32_LR_W  32'b00010_??_00000_?????_010_?????_0101111
`define RV32_BEQ   32'b???????_?????_?????_000_?????_1100011
`define RV32_BNE   32'b???????_?????_?????_001_?????_1100011
`define RV32_BLT   32'b???????_?????_?????_100_?????_1100011
`define RV32_BGE   32'b???????_?????_?????_101_?????_1100011
`define RV32_BLTU  32'b???????_?????_?????_110_?????_1100011
`define RV32_BGEU  32'b???????_?????_?????_111_?????_1100011
`define RV32_LB    32'b????????????_?????_000_?????_0000011
`define RV32_LH    32'b????????????_?????_001_?????_0000011
`define RV32_LW    32'b????????????_?????_010_?????_0000011
`define RV32_LBU   32'b????????????_?????_100_?????_0000011
`define RV32_LHU   32'b????????????_?????_101_?????_0000011
`define RV32_SB    32'b???????_?????_?????_000_?????_0100011
`define RV32_SH    32'b???????_?????_?????_001_?????_0100011
`define RV32_SW    32'b???????_?????_?????_010_?????_0100011
`define RV32_ADDI  32'b????????????_?????_000_?????_0010011
`define RV32_SLTI  32'b????????????_?????_010_?????_0010011
`define RV32_SLTIU 32'b????????????_?????_011_?????_0010011
`define RV32_XORI  32'b????????????_?????_100_?????_0010011
`define RV32_ORI   32'b????????????_?????_110_?????_0010011
`define RV32_ANDI  32'b????????????_?????_111_?????_0010011
`define RV32_SLLI  32'b0000000_?????_?????_001_?????_0010011
`define RV32_SRLI  32'b0000000_?????_?????_101_?????_0010011
`define RV32_SRAI  32'b0100000_?????_?????_101_?????_0010011
`define RV32_ADD   32'b0000000_?????_?????_000_?????_0110011
`define RV32_SUB   32'b0100000_?????_?????_000_?????_0110011
`define RV32_SLL   32'b0000000_?????_?????_001_?????_0110011
`define RV32_SLT   32'b0000000_?????_?????_010_?????_0110011
`define RV32_SLTU  32'b0000000_?????_?????_011_?????_0110011
`define RV32_XOR   32'b0000000_?????_?????_100_?????_0110011
`define RV32_SRL   32'b0000000_?????_?????_101_?????_0110011
`define RV32_SRA   32'b0100000_?????_?????_101_?????_0110011
`define RV32_OR    32'b0000000_?????_?????_110_?????_0110011
`define RV32_AND   32'b0000000_?????_?????_111_?????_0110011

// immediates, each widened to 32 bits.
`define RV32_signext_Iimm(instr) {{21{instr[31]}}, instr[30:20]}
`define RV32_signext_Simm(instr) {{21{instr[31]}}, instr[30:25], instr[11:7]}
`define RV32_signext_Uimm(instr) {instr[31:12], 12'b0}

`endif
